//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tbDecodeFrontEnd
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+src
src/isaPkg.sv
src/frontEndPkg.sv
src/frontEndIf.sv
src/fetchUnit.sv
src/instructionQueue.sv
src/instructionDecoder.sv
src/decodeStage.sv
src/decodeFrontEnd.sv
test/clockGen.sv
test/decodeFrontEnd_assert.sv
test/tbDecodeFrontEnd.sv

//--- src/decodeFrontEnd.sv
`include "frontEnd_config.svh"

module decodeFrontEnd (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   imemWrEn,
    input  frontEndPkg::pc_t       imemWrAddr,
    input  frontEndPkg::instr_t    imemWrData,
    input  logic                   run,
    input  logic                   redirect,
    input  frontEndPkg::pc_t       redirectPc,
    input  logic                   stall,
    output logic                   decValid,
    output frontEndPkg::pc_t       pc,
    output isaPkg::majorOp_e       majorOp,
    output logic [3:0]             minorOp,
    output logic [3:0]             operandAAddr,
    output logic                   readingFromA,
    output logic                   writingToA,
    output logic [3:0]             operandBAddr,
    output logic                   readingFromB,
    output logic                   jalHazard,
    output logic [`DATA_WIDTH-1:0] immediate
);
    import frontEndPkg::*;

    fetchQueueIf  fqIf ();        // Fetch to queue
    queueDecodeIf qdIf ();        // Queue to decode
    queueCount_t  used;           // Occupancy back to fetch
    decoded_t     decOut;

    fetchUnit fetchUnit_inst (
        .clk, .rstN, .imemWrEn, .imemWrAddr, .imemWrData,
        .run, .redirect, .redirectPc, .used, .q (fqIf.producer)
    );

    instructionQueue instructionQueue_inst (
        .clk, .rstN, .flush (redirect), .used, .in (fqIf.queue), .out (qdIf.queue)
    );

    decodeStage decodeStage_inst (
        .clk, .rstN, .stall, .flush (redirect), .in (qdIf.consumer), .decValid, .decOut
    );

    assign pc           = decOut.pc;      // Flattened decode result
    assign majorOp      = decOut.majorOp;
    assign minorOp      = decOut.minorOp;
    assign operandAAddr = decOut.operandAAddr;
    assign readingFromA = decOut.readingFromA;
    assign writingToA   = decOut.writingToA;
    assign operandBAddr = decOut.operandBAddr;
    assign readingFromB = decOut.readingFromB;
    assign jalHazard    = decOut.jalHazard;
    assign immediate    = decOut.immediate;

endmodule

//--- src/decodeStage.sv
module decodeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  flush,
    queueDecodeIf.consumer        in,
    output logic                  decValid,
    output frontEndPkg::decoded_t decOut
);
    import frontEndPkg::*;

    decoded_t decNext;        // Decoder view of the queue head
    logic     doPop;

    // Flush cycle pops nothing, the queue is emptied anyway
    assign doPop  = !in.empty && !stall && !flush;
    assign in.pop = doPop;

    instructionDecoder decoder_inst (
        .instr   (in.popInstr),
        .pc      (in.popPc),
        .decoded (decNext)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (flush) begin
            decValid <= 1'b0;     // Nothing survives a redirect
        end else if (!stall) begin
            decValid <= doPop;    // One cycle per popped entry
        end
    end

    // Output register only moves on a pop, so stall holds it
    always_ff @(posedge clk) begin
        if (doPop) decOut <= decNext;
    end

endmodule

//--- src/fetchUnit.sv
`include "frontEnd_config.svh"

module fetchUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     imemWrEn,
    input  frontEndPkg::pc_t         imemWrAddr,
    input  frontEndPkg::instr_t      imemWrData,
    input  logic                     run,
    input  logic                     redirect,
    input  frontEndPkg::pc_t         redirectPc,
    input  frontEndPkg::queueCount_t used,
    fetchQueueIf.producer            q
);
    import frontEndPkg::*;

    instr_t      imem [`IMEM_DEPTH]; // Program storage, loaded by the testbench
    pc_t         pc;                 // Next address to read
    fetchState_e state;
    logic        rdValid;            // Read issued last cycle, lands now
    pc_t         rdPc;
    instr_t      rdData;
    logic        issue;

    // Room check counts the read already in flight
    assign issue = (state == running) && !redirect && !q.full &&
                   ((int'(used) + int'(rdValid)) < `QUEUE_DEPTH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (run) state <= running;
                running: if (!run) state <= idle;   // Finish the current read only
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            rdValid <= 1'b0;
        end else if (redirect) begin
            pc      <= redirectPc;   // Restart point
            rdValid <= 1'b0;         // Cancel outstanding read
        end else begin
            rdValid <= issue;
            if (issue) pc <= pc + 1'b1; // Wraps at memory end
        end
    end

    // Synchronous memory, one cycle read
    always_ff @(posedge clk) begin
        if (imemWrEn) imem[imemWrAddr] <= imemWrData;
        if (issue) begin
            rdData <= imem[pc];
            rdPc   <= pc;           // Tag travels with the word
        end
    end

    assign q.push      = rdValid && !redirect; // Data of a cancelled read is dropped
    assign q.pushPc    = rdPc;
    assign q.pushInstr = rdData;

endmodule

//--- src/frontEndIf.sv
// Fetch unit to instruction queue
interface fetchQueueIf;
    import frontEndPkg::*;

    logic   push;        // One entry written this cycle
    logic   full;        // No free entry
    pc_t    pushPc;
    instr_t pushInstr;

    modport producer (output push, output pushPc, output pushInstr, input full);
    modport queue (input push, input pushPc, input pushInstr, output full);
endinterface

// Instruction queue to decode stage
interface queueDecodeIf;
    import frontEndPkg::*;

    logic   pop;         // Head consumed at the edge
    logic   empty;       // Head not valid
    pc_t    popPc;       // Head entry, combinational
    instr_t popInstr;

    modport queue (input pop, output empty, output popPc, output popInstr);
    modport consumer (output pop, input empty, input popPc, input popInstr);
endinterface

//--- src/frontEndPkg.sv
`include "frontEnd_config.svh"

package frontEndPkg;

    typedef logic [`PC_WIDTH-1:0] pc_t;
    typedef logic [15:0] instr_t;                               // Fixed 16-bit encoding
    typedef logic [$clog2(`QUEUE_DEPTH + 1) - 1:0] queueCount_t; // Occupancy 0 to depth

    // Registered decode result
    typedef struct packed {
        pc_t              pc;           // Address of the instruction
        isaPkg::majorOp_e majorOp;
        logic [3:0]       minorOp;
        logic [3:0]       operandAAddr;
        logic             readingFromA;
        logic             writingToA;
        logic [3:0]       operandBAddr;
        logic             readingFromB;
        logic             jalHazard;    // PC needed as an operand
        logic [`DATA_WIDTH-1:0] immediate;
    } decoded_t;

    typedef enum logic {
        idle    = 1'b0, // No reads issued
        running = 1'b1  // Walking the PC
    } fetchState_e;

endpackage

//--- src/frontEnd_config.svh
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Immediate and datapath width
`define DATA_WIDTH 16

`define PC_WIDTH 8        // Word address into instruction memory
`define QUEUE_DEPTH 4     // Entries between fetch and decode
`define IMEM_DEPTH 256    // Instruction memory words

`endif

//--- src/instructionDecoder.sv
`include "frontEnd_config.svh"

module instructionDecoder (
    input  frontEndPkg::instr_t   instr,
    input  frontEndPkg::pc_t      pc,
    output frontEndPkg::decoded_t decoded
);
    import isaPkg::*;
    import frontEndPkg::*;

    majorOp_e      majorOp;
    immFormat_e    immFormat;
    logic [3:0]    minorOp;
    operandFlags_t opFlags;      // Write A, read A, read B

    // Minor-opcode classes keep one bit per minor code in each mask
    function automatic operandFlags_t fromMasks(
        input logic [15:0] writeMask,
        input logic [15:0] readAMask,
        input logic [15:0] readBMask,
        input logic [3:0]  minor
    );
        operandFlags_t f;
        f.writeA = writeMask[minor];
        f.readA  = readAMask[minor];
        f.readB  = readBMask[minor];
        return f;
    endfunction

    assign majorOp   = majorOp_e'(instr[15:12]);
    assign immFormat = immFormat_e'(instr[13:12]);
    assign minorOp   = instr[7:4];

    always_comb begin : operandFlagsMux
        case (majorOp)
            // Inc, Dec, Move and NOT B leave A unread
            simple0:    opFlags = fromMasks(16'hFFFF, 16'h7F75, 16'hFFFF, minorOp);
            // Bit scans and reverse read B only
            simple1:    opFlags = fromMasks(16'hFFFF, 16'h8FFF, 16'hFFFF, minorOp);
            complex:    opFlags = fromMasks(16'h0003, 16'h0003, 16'h0003, minorOp); // Mult only
            // Plain loads write A, stores read A
            memory:     opFlags = fromMasks(16'hFF0F, 16'hFFF0, 16'hFFFF, minorOp);
            privileged: opFlags = fromMasks(16'h05F0, 16'h02C4, 16'h07F0, minorOp);
            loadShiftedByte,
            loadUnsignedLower,
            loadUnsignedExtended,
            loadUpper,
            loadNegativeExtended: opFlags = 3'b100;      // Immediate into A
            jalReg,
            branchReg:  opFlags = 3'b011;               // Link or test A, target in B
            jalRel,
            branchRel:  opFlags = 3'b010;               // Offset from immediate
            default:    opFlags = 3'b000;               // Reserved encodings
        endcase
    end

    always_comb begin : outputAssembly
        decoded              = '0;
        decoded.pc           = pc;
        decoded.majorOp      = majorOp;
        decoded.minorOp      = minorOp;
        decoded.writingToA   = opFlags.writeA;
        decoded.readingFromA = opFlags.readA;
        decoded.readingFromB = opFlags.readB;
        decoded.operandBAddr = instr[3:0];

        // Register-pair forms squeeze A into bits 11:10 plus bit 14
        decoded.operandAAddr = (instr[15] && instr[12]) ?
                               {instr[11:10], 1'b0, instr[14]} : instr[11:8];

        // Link target is the PC itself when the address bits are all zero
        decoded.jalHazard = ((majorOp == jalRel) && (instr[11:10] == 2'b00)) ||
                            ((majorOp == jalReg) && (instr[11:8] == 4'h0));

        case (immFormat)
            zeroExt8: decoded.immediate[7:0]  = instr[7:0];
            upper8:   decoded.immediate[15:8] = instr[7:0];   // Low byte stays zero
            default:  decoded.immediate = {{(`DATA_WIDTH - 10){instr[14]}}, instr[9:0]};
        endcase
    end

endmodule

//--- src/instructionQueue.sv
`include "frontEnd_config.svh"

module instructionQueue (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flush,
    output frontEndPkg::queueCount_t used,
    fetchQueueIf.queue               in,
    queueDecodeIf.queue              out
);
    import frontEndPkg::*;

    localparam int ptrWidth = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    typedef logic [ptrWidth-1:0] ptr_t;

    pc_t         pcMem [`QUEUE_DEPTH];    // PC tag per slot
    instr_t      instrMem [`QUEUE_DEPTH];
    ptr_t        wrPtr;
    ptr_t        rdPtr;                   // Head slot
    queueCount_t count;
    logic        doPush;
    logic        doPop;

    // Circular increment, depth need not be a power of two
    function automatic ptr_t advance(input ptr_t p);
        return (p == ptr_t'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign doPush = in.push && !in.full;
    assign doPop  = out.pop && !out.empty;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;             // Redirect discards everything
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= advance(wrPtr);
            if (doPop) rdPtr <= advance(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            pcMem[wrPtr]    <= in.pushPc;
            instrMem[wrPtr] <= in.pushInstr;
        end
    end

    assign in.full      = (count == queueCount_t'(`QUEUE_DEPTH));
    assign out.empty    = (count == '0);
    assign out.popPc    = pcMem[rdPtr];     // Head visible without a pop
    assign out.popInstr = instrMem[rdPtr];
    assign used         = count;

endmodule

//--- src/isaPkg.sv
package isaPkg;

    // Major opcode sits in instruction bits 15:12
    typedef enum logic [3:0] {
        simple0              = 4'h0, // ALU ops, first group
        simple1              = 4'h1, // Bit and shift ops
        complex              = 4'h2, // Multiply
        memory               = 4'h3, // Loads, stores, atomics
        loadShiftedByte      = 4'h4,
        reserved5            = 4'h5, // Unused encoding
        privileged           = 4'h6, // CSR, stack, system
        reserved7            = 4'h7, // Unused encoding
        jalReg               = 4'h8, // Jump and link, register target
        jalRel               = 4'h9, // Jump and link, PC relative
        branchReg            = 4'hA, // Branch if zero, register target
        branchRel            = 4'hB, // Branch if zero, PC relative
        loadUnsignedLower    = 4'hC,
        loadUnsignedExtended = 4'hD,
        loadUpper            = 4'hE, // Byte lands in upper half
        loadNegativeExtended = 4'hF
    } majorOp_e;

    // Immediate shape chosen by bits 13:12
    typedef enum logic [1:0] {
        zeroExt8     = 2'b00, // Bits 7:0, zero filled
        signExt10    = 2'b01, // Bits 9:0, bit 14 as sign
        upper8       = 2'b10, // Bits 7:0 shifted up a byte
        signExt10Alt = 2'b11  // Same as signExt10
    } immFormat_e;

    // Operand usage of one instruction
    typedef struct packed {
        logic writeA;         // Result goes to register A
        logic readA;          // Register A is a source
        logic readB;          // Register B is a source
    } operandFlags_t;

endpackage

//--- test/clockGen.sv
module clockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // Period 8
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);  // Three cycles in reset
        #1 rstN = 1'b1;
    end
endmodule

//--- test/decodeFrontEnd_assert.sv
module decodeFrontEnd_assert (
    input logic                     clk,
    input logic                     rstN,
    input logic                     stall,
    input logic                     decValid,
    input logic                     push,
    input logic                     full,
    input logic                     empty,
    input frontEndPkg::queueCount_t used,
    input frontEndPkg::decoded_t    decOut
);
    // Fetch holds off on a full queue
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN) !(push && full))
        else $error("Push into a full instruction queue");

    // Empty queue gains at most the one pushed entry
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        empty |=> (used <= 1))
        else $error("Pop from an empty instruction queue");

    // Stalled result stays put
    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        (stall && decValid) |=> $stable(decOut))
        else $error("Decode output changed under stall");
endmodule

bind decodeFrontEnd decodeFrontEnd_assert decodeFrontEnd_assert_inst (
    .clk, .rstN, .stall, .decValid,
    .push (fqIf.push), .full (fqIf.full), .empty (qdIf.empty), .used,
    .decOut
);

//--- test/tbDecodeFrontEnd.sv
`include "frontEnd_config.svh"

module tbDecodeFrontEnd;
    import isaPkg::*;
    import frontEndPkg::*;

    localparam int sweepLen    = 256;
    localparam int totalLoaded = sweepLen + 16 + 16 + 64 + 16 + 8;
    localparam int cycleLimit  = 40 * totalLoaded + 200;   // Abort point

    logic clk, rstN, imemWrEn, run, redirect, stall;
    pc_t imemWrAddr, redirectPc, pc;
    instr_t imemWrData;
    logic decValid, readingFromA, writingToA, readingFromB, jalHazard;
    majorOp_e majorOp;
    logic [3:0] minorOp, operandAAddr, operandBAddr;
    logic [`DATA_WIDTH-1:0] immediate;

    decoded_t actWord;                    // Ports regathered into one word
    decoded_t expected [$];
    decoded_t received [$];
    instr_t   progMem [`IMEM_DEPTH];      // Shadow of the loaded program
    integer   seed;
    int       errorCount = 0;
    int       checkTotal = 0;
    int       wantCount = 0;
    int       cycleCount;
    int       stallSpan = 0;
    logic     collecting = 1'b0;
    logic     stallEnable = 1'b0;
    logic     stallArmed = 1'b0;
    logic     stallPrev = 1'b0;

    clockGen clockGen_inst (.clk, .rstN);

    decodeFrontEnd decodeFrontEnd_inst (
        .clk, .rstN, .imemWrEn, .imemWrAddr, .imemWrData, .run, .redirect, .redirectPc,
        .stall, .decValid, .pc, .majorOp, .minorOp, .operandAAddr, .readingFromA,
        .writingToA, .operandBAddr, .readingFromB, .jalHazard, .immediate
    );

    always_comb begin
        actWord              = '0;
        actWord.pc           = pc;
        actWord.majorOp      = majorOp;
        actWord.minorOp      = minorOp;
        actWord.operandAAddr = operandAAddr;
        actWord.readingFromA = readingFromA;
        actWord.writingToA   = writingToA;
        actWord.operandBAddr = operandBAddr;
        actWord.readingFromB = readingFromB;
        actWord.jalHazard    = jalHazard;
        actWord.immediate    = immediate;
    end

    // Operand table with one bit per minor code in each flag mask
    function automatic logic [2:0] refFlags(input majorOp_e op, input logic [3:0] minor);
        logic [15:0] wm, am, bm;
        wm = '0;
        am = '0;
        bm = '0;
        case (op)
            simple0:    {wm, am, bm} = {16'hFFFF, 16'h7F75, 16'hFFFF};
            simple1:    {wm, am, bm} = {16'hFFFF, 16'h8FFF, 16'hFFFF};
            complex:    {wm, am, bm} = {16'h0003, 16'h0003, 16'h0003};
            memory:     {wm, am, bm} = {16'hFF0F, 16'hFFF0, 16'hFFFF};
            privileged: {wm, am, bm} = {16'h05F0, 16'h02C4, 16'h07F0};
            loadShiftedByte, loadUnsignedLower, loadUnsignedExtended,
            loadUpper, loadNegativeExtended: wm = '1;
            jalReg, branchReg: {am, bm} = '1;
            jalRel, branchRel: am = '1;
            default: ;                        // Reserved encodings use nothing
        endcase
        return {wm[minor], am[minor], bm[minor]};
    endfunction

    function automatic decoded_t refDecode(input instr_t w, input pc_t at);
        decoded_t d;
        logic [2:0] fl;
        d              = '0;
        d.pc           = at;
        d.majorOp      = majorOp_e'(w[15:12]);
        d.minorOp      = w[7:4];
        fl             = refFlags(d.majorOp, w[7:4]);
        d.writingToA   = fl[2];
        d.readingFromA = fl[1];
        d.readingFromB = fl[0];
        d.operandBAddr = w[3:0];
        d.operandAAddr = (w[15] && w[12]) ? {w[11:10], 1'b0, w[14]} : w[11:8];
        d.jalHazard    = (d.majorOp == jalRel && w[11:10] == 2'b00) ||
                         (d.majorOp == jalReg && w[11:8] == 4'h0);
        case (w[13:12])
            2'b00:   d.immediate = `DATA_WIDTH'(w[7:0]);
            2'b10:   d.immediate = `DATA_WIDTH'({w[7:0], 8'h00});
            default: d.immediate = {{(`DATA_WIDTH - 10){w[14]}}, w[9:0]};  // Sign from bit 14
        endcase
        return d;
    endfunction

    task automatic checkDecoded(input string name, input decoded_t exp, input decoded_t act);
        checkTotal++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkMajor(input string name, input majorOp_e exp, input majorOp_e act);
        checkTotal++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input integer exp, input integer act);
        checkTotal++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // A new result shows only if the previous cycle was not stalled
    always @(negedge clk) begin
        if (collecting && decValid && !stallPrev && received.size() < wantCount)
            received.push_back(actWord);
        stallPrev = stall;
    end

    always @(posedge clk) begin
        stallArmed = stallEnable;             // Taken at the edge ahead of the main thread
        #1;
        if (!stallArmed) begin
            stall = 1'b0;
        end else if (stallSpan > 0) begin
            stall = 1'b1;
            stallSpan--;
        end else begin
            stall = 1'b0;
            if (($random(seed) & 3) == 0)
                stallSpan = 1 + ($unsigned($random(seed)) % 7);   // Span of 1 to 7
        end
    end

    task automatic writeWord(input pc_t addr, input instr_t data);
        imemWrEn   = 1'b1;
        imemWrAddr = addr;
        imemWrData = data;
        progMem[addr] = data;
        @(posedge clk);
        #1;
        imemWrEn = 1'b0;
    endtask

    // Redirect to startPc with run high and expect n results
    task automatic startFetch(input pc_t startPc, input int n);
        collecting = 1'b0;
        expected.delete();
        received.delete();
        for (int k = 0; k < n; k++)
            expected.push_back(refDecode(progMem[pc_t'(startPc + k)], pc_t'(startPc + k)));
        wantCount  = n;
        redirect   = 1'b1;
        redirectPc = startPc;
        run        = 1'b1;
        @(posedge clk);
        #1;
        redirect   = 1'b0;
        collecting = 1'b1;
    endtask

    // Budget covers the longest stall spans
    task automatic waitOutputs();
        int waited;
        waited = 0;
        while (received.size() < wantCount && waited < 40 * wantCount) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (received.size() < wantCount)
            $display("Missing decoded outputs, only %0d of %0d arrived",
                     received.size(), wantCount);
    endtask

    task automatic compareOutputs(input string name);
        checkCount({"output count ", name}, expected.size(), received.size());
        foreach (received[k]) begin
            checkMajor($sformatf("majorOp[%0d] %s", k, name), expected[k].majorOp,
                       received[k].majorOp);
            checkDecoded($sformatf("decOut[%0d] %s", k, name), expected[k], received[k]);
        end
    endtask

    task automatic stopFetch();
        collecting = 1'b0;
        run        = 1'b0;
        redirect   = 1'b1;                    // Drops the queue and any read in flight
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic runAndCompare(input pc_t startPc, input int n, input string name);
        startFetch(startPc, n);
        waitOutputs();
        compareOutputs(name);
        stopFetch();
    endtask

    task automatic testOpcodeSweep();
        int r;
        for (int i = 0; i < sweepLen; i++) begin
            r = $random(seed);
            writeWord(pc_t'(i), {i[7:4], r[3:0], i[3:0], r[7:4]});   // Major and minor from i
        end
        runAndCompare(8'h00, sweepLen, "opcode sweep");
    endtask

    task automatic testImmediateFormats();
        int r;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            writeWord(pc_t'(i), {r[15], i[0], i[2:1], r[11:0]});     // Sign bit and format
        end
        runAndCompare(8'h00, 16, "immediate formats");
    endtask

    task automatic testJalHazard();
        int r;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            writeWord(pc_t'(8'h20 + i), {(i[0] ? jalRel : jalReg), i[3:1], i[3], r[7:0]});
        end
        runAndCompare(8'h20, 16, "jal hazard");
    endtask

    task automatic testStallBackPressure();
        for (int i = 0; i < 64; i++)
            writeWord(pc_t'(8'hE0 + i), instr_t'($random(seed)));     // Wraps past 0xFF
        stallEnable = 1'b1;
        startFetch(8'hE0, 64);
        waitOutputs();
        stallEnable = 1'b0;
        compareOutputs("stall back-pressure");
        stopFetch();
    endtask

    task automatic testRedirectFlush();
        int stale;
        for (int i = 0; i < 16; i++)
            writeWord(pc_t'(8'h40 + i), instr_t'($random(seed)));
        for (int i = 0; i < 8; i++)
            writeWord(pc_t'(8'h90 + i), instr_t'($random(seed)));
        startFetch(8'h40, 5);
        waitOutputs();
        compareOutputs("before redirect");
        startFetch(8'h90, 8);                 // Program A still streaming
        waitOutputs();
        compareOutputs("after redirect");
        stale = 0;
        foreach (received[k])
            if (received[k].pc inside {[8'h40:8'h4F]}) stale++;
        checkCount("stale outputs after redirect", 0, stale);
        stopFetch();
    endtask

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, only %0d of %0d decoded outputs arrived",
                 cycleCount, received.size(), wantCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed       = 32'h036c41ac;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        run        = 1'b0;
        redirect   = 1'b0;
        redirectPc = '0;
        stall      = 1'b0;
        wait (rstN);
        @(posedge clk);
        #1;
        testOpcodeSweep();
        testImmediateFormats();
        testJalHazard();
        testStallBackPressure();
        testRedirectFlush();
        $display("Checks run: %0d, errors: %0d", checkTotal, errorCount);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end
endmodule
